//--- rtl/rob_core_pkg.sv
package rob_core_pkg;

    localparam int xlen = 32;
    localparam int rd_w = 5;

    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_xor = 3'd2,
        op_mul = 3'd3,
        op_jal = 3'd4,
        op_beq = 3'd5
    } op_t;

    typedef enum logic {
        st_run   = 1'b0,
        st_flush = 1'b1
    } rob_state_t;

    // execution cycles per opcode
    function automatic logic [2:0] op_latency(input op_t op);
        case (op)
            op_sub, op_beq: return 3'd2;
            op_mul:         return 3'd4;
            default:        return 3'd1;
        endcase
    endfunction

    function automatic logic [xlen-1:0] calc_data(input op_t op, input logic [xlen-1:0] a,
                                                  input logic [xlen-1:0] b,
                                                  input logic [xlen-1:0] pc);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_xor:  return a ^ b;
            op_mul:  return a * b;
            op_jal:  return pc + xlen'(4);
            default: return '0;
        endcase
    endfunction

    // next pc after the instruction resolves
    function automatic logic [xlen-1:0] calc_jpc(input op_t op, input logic [xlen-1:0] a,
                                                 input logic [xlen-1:0] b,
                                                 input logic [xlen-1:0] pc);
        case (op)
            op_jal:  return pc + a;
            op_beq:  return (a == b) ? pc + b : pc + xlen'(4);
            default: return pc + xlen'(4);
        endcase
    endfunction

endpackage

//--- rtl/dispatch_queue.sv
`timescale 1ns/100ps

module dispatch_queue import rob_core_pkg::*; #(
    parameter int DQ_DEPTH   = 4,
    parameter int ROB_DEPTH  = 8,
    parameter int EXEC_SLOTS = 3
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  op_t             in_op,
    input  logic [rd_w-1:0] in_rd,
    input  logic [xlen-1:0] in_a,
    input  logic [xlen-1:0] in_b,
    input  logic [xlen-1:0] in_pc,
    input  logic            rob_credit,
    input  logic            exec_credit,
    input  logic            flush,
    output logic            in_credit,
    output logic            dq_issue,
    output op_t             dq_op,
    output logic [rd_w-1:0] dq_rd,
    output logic [xlen-1:0] dq_a,
    output logic [xlen-1:0] dq_b,
    output logic [xlen-1:0] dq_pc
);

    localparam int ptr_w = (DQ_DEPTH > 1) ? $clog2(DQ_DEPTH) : 1;
    localparam int cnt_w = $clog2(DQ_DEPTH + 1);
    localparam int rc_w  = $clog2(ROB_DEPTH + 1);
    localparam int ec_w  = $clog2(EXEC_SLOTS + 1);

    op_t             q_op [DQ_DEPTH];
    logic [rd_w-1:0] q_rd [DQ_DEPTH];
    logic [xlen-1:0] q_a  [DQ_DEPTH];
    logic [xlen-1:0] q_b  [DQ_DEPTH];
    logic [xlen-1:0] q_pc [DQ_DEPTH];

    logic [ptr_w-1:0] head;
    logic [ptr_w-1:0] tail;
    logic [cnt_w-1:0] count;
    logic [rc_w-1:0]  rob_cnt;
    logic [ec_w-1:0]  exec_cnt;
    logic             wr;

    // depth need not be a power of two
    function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(DQ_DEPTH - 1)) ? '0 : p + ptr_w'(1);
    endfunction

    assign wr       = in_valid && !flush;
    assign dq_issue = (count != '0) && (rob_cnt != '0) && (exec_cnt != '0) && !flush;

    assign dq_op = q_op[head];
    assign dq_rd = q_rd[head];
    assign dq_a  = q_a[head];
    assign dq_b  = q_b[head];
    assign dq_pc = q_pc[head];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            rob_cnt   <= rc_w'(ROB_DEPTH);
            exec_cnt  <= ec_w'(EXEC_SLOTS);
            in_credit <= 1'b0;
        end else if (flush) begin
            // rob and exec drain in the same cycle
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            rob_cnt   <= rc_w'(ROB_DEPTH);
            exec_cnt  <= ec_w'(EXEC_SLOTS);
            in_credit <= 1'b0;
        end else begin
            in_credit <= dq_issue;
            if (wr) begin
                tail <= ptr_next(tail);
            end
            if (dq_issue) begin
                head <= ptr_next(head);
            end
            count    <= count + cnt_w'(wr) - cnt_w'(dq_issue);
            rob_cnt  <= rob_cnt + rc_w'(rob_credit) - rc_w'(dq_issue);
            exec_cnt <= exec_cnt + ec_w'(exec_credit) - ec_w'(dq_issue);
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            q_op[tail] <= in_op;
            q_rd[tail] <= in_rd;
            q_a[tail]  <= in_a;
            q_b[tail]  <= in_b;
            q_pc[tail] <= in_pc;
        end
    end

endmodule

//--- rtl/exec_unit.sv
`timescale 1ns/100ps

module exec_unit import rob_core_pkg::*; #(
    parameter int EXEC_SLOTS = 3
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            dq_issue,
    input  op_t             dq_op,
    input  logic [xlen-1:0] dq_a,
    input  logic [xlen-1:0] dq_b,
    input  logic [xlen-1:0] dq_pc,
    input  logic            flush,
    output logic            exec_credit,
    output logic            cmpl_valid,
    output logic [xlen-1:0] cmpl_pc,
    output logic [xlen-1:0] cmpl_data,
    output logic [xlen-1:0] cmpl_jpc
);

    localparam int slot_w = (EXEC_SLOTS > 1) ? $clog2(EXEC_SLOTS) : 1;

    logic [EXEC_SLOTS-1:0] busy;
    logic [2:0]            cnt       [EXEC_SLOTS];
    logic [xlen-1:0]       slot_pc   [EXEC_SLOTS];
    logic [xlen-1:0]       slot_data [EXEC_SLOTS];
    logic [xlen-1:0]       slot_jpc  [EXEC_SLOTS];

    logic              free_found;
    logic              done_found;
    logic [slot_w-1:0] free_idx;
    logic [slot_w-1:0] done_idx;

    // scan downward so the lowest index wins
    always_comb begin
        free_found = 1'b0;
        done_found = 1'b0;
        free_idx   = '0;
        done_idx   = '0;
        for (int i = EXEC_SLOTS - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_found = 1'b1;
                free_idx   = slot_w'(i);
            end
            if (busy[i] && cnt[i] == 3'd0) begin
                done_found = 1'b1;
                done_idx   = slot_w'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy        <= '0;
            cmpl_valid  <= 1'b0;
            exec_credit <= 1'b0;
            for (int i = 0; i < EXEC_SLOTS; i++) begin
                cnt[i] <= 3'd0;
            end
        end else if (flush) begin
            busy        <= '0;
            cmpl_valid  <= 1'b0;
            exec_credit <= 1'b0;
        end else begin
            cmpl_valid  <= done_found;
            exec_credit <= done_found;
            for (int i = 0; i < EXEC_SLOTS; i++) begin
                if (busy[i] && cnt[i] != 3'd0) begin
                    cnt[i] <= cnt[i] - 3'd1;
                end
            end
            if (done_found) begin
                busy[done_idx] <= 1'b0;
            end
            // result is ready once the countdown hits zero
            if (dq_issue && free_found) begin
                busy[free_idx] <= 1'b1;
                cnt[free_idx]  <= op_latency(dq_op) - 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dq_issue && free_found) begin
            slot_pc[free_idx]   <= dq_pc;
            slot_data[free_idx] <= calc_data(dq_op, dq_a, dq_b, dq_pc);
            slot_jpc[free_idx]  <= calc_jpc(dq_op, dq_a, dq_b, dq_pc);
        end
        if (done_found) begin
            cmpl_pc   <= slot_pc[done_idx];
            cmpl_data <= slot_data[done_idx];
            cmpl_jpc  <= slot_jpc[done_idx];
        end
    end

endmodule

//--- rtl/rob.sv
`timescale 1ns/100ps

module rob import rob_core_pkg::*; #(
    parameter int ROB_DEPTH = 8
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            dq_issue,
    input  logic [rd_w-1:0] dq_rd,
    input  logic [xlen-1:0] dq_pc,
    input  logic            cmpl_valid,
    input  logic [xlen-1:0] cmpl_pc,
    input  logic [xlen-1:0] cmpl_data,
    input  logic [xlen-1:0] cmpl_jpc,
    output logic            rob_credit,
    output logic            commit_valid,
    output logic [xlen-1:0] commit_pc,
    output logic [rd_w-1:0] commit_rd,
    output logic [xlen-1:0] commit_data,
    output logic            redirect_valid,
    output logic [xlen-1:0] redirect_pc
);

    localparam int ptr_w = $clog2(ROB_DEPTH);

    rob_state_t state;

    logic [ptr_w-1:0] head;
    logic [ptr_w-1:0] tail;

    logic [ROB_DEPTH-1:0] e_valid;
    logic [ROB_DEPTH-1:0] e_fin;
    logic [xlen-1:0]      e_pc   [ROB_DEPTH];
    logic [rd_w-1:0]      e_rd   [ROB_DEPTH];
    logic [xlen-1:0]      e_data [ROB_DEPTH];
    logic [xlen-1:0]      e_jpc  [ROB_DEPTH];

    logic [ROB_DEPTH-1:0] hit;
    logic                 retire;
    logic                 mispredict;

    // pcs in flight are unique, so at most one entry hits
    always_comb begin
        for (int i = 0; i < ROB_DEPTH; i++) begin
            hit[i] = cmpl_valid && e_valid[i] && (e_pc[i] == cmpl_pc);
        end
    end

    assign retire     = (state == st_run) && e_valid[head] && e_fin[head];
    assign mispredict = e_jpc[head] != e_pc[head] + xlen'(4);

    assign redirect_valid = (state == st_flush);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= st_run;
            head         <= '0;
            tail         <= '0;
            e_valid      <= '0;
            e_fin        <= '0;
            commit_valid <= 1'b0;
            rob_credit   <= 1'b0;
        end else if (state == st_flush) begin
            // drop everything younger than the redirecting instruction
            state        <= st_run;
            head         <= '0;
            tail         <= '0;
            e_valid      <= '0;
            e_fin        <= '0;
            commit_valid <= 1'b0;
            rob_credit   <= 1'b0;
        end else begin
            commit_valid <= retire;
            rob_credit   <= retire;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                if (hit[i]) begin
                    e_fin[i] <= 1'b1;
                end
            end
            if (retire) begin
                e_valid[head] <= 1'b0;
                head          <= head + ptr_w'(1);
                if (mispredict) begin
                    state <= st_flush;
                end
            end
            // credits keep tail off a live entry
            if (dq_issue) begin
                e_valid[tail] <= 1'b1;
                e_fin[tail]   <= 1'b0;
                tail          <= tail + ptr_w'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_run) begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                if (hit[i]) begin
                    e_data[i] <= cmpl_data;
                    e_jpc[i]  <= cmpl_jpc;
                end
            end
            if (dq_issue) begin
                e_pc[tail] <= dq_pc;
                e_rd[tail] <= dq_rd;
            end
        end
        if (retire) begin
            commit_pc   <= e_pc[head];
            commit_rd   <= e_rd[head];
            commit_data <= e_data[head];
            redirect_pc <= e_jpc[head];
        end
    end

endmodule

//--- rtl/rob_core_top.sv
`timescale 1ns/100ps

module rob_core_top import rob_core_pkg::*; #(
    parameter int DQ_DEPTH   = 4,
    parameter int ROB_DEPTH  = 8,
    parameter int EXEC_SLOTS = 3
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  op_t             in_op,
    input  logic [rd_w-1:0] in_rd,
    input  logic [xlen-1:0] in_a,
    input  logic [xlen-1:0] in_b,
    input  logic [xlen-1:0] in_pc,
    output logic            in_credit,
    output logic            commit_valid,
    output logic [xlen-1:0] commit_pc,
    output logic [rd_w-1:0] commit_rd,
    output logic [xlen-1:0] commit_data,
    output logic            redirect_valid,
    output logic [xlen-1:0] redirect_pc
);

    logic            rob_credit;
    logic            exec_credit;
    logic            dq_issue;
    op_t             dq_op;
    logic [rd_w-1:0] dq_rd;
    logic [xlen-1:0] dq_a;
    logic [xlen-1:0] dq_b;
    logic [xlen-1:0] dq_pc;
    logic            cmpl_valid;
    logic [xlen-1:0] cmpl_pc;
    logic [xlen-1:0] cmpl_data;
    logic [xlen-1:0] cmpl_jpc;

    dispatch_queue #(
        .DQ_DEPTH   (DQ_DEPTH),
        .ROB_DEPTH  (ROB_DEPTH),
        .EXEC_SLOTS (EXEC_SLOTS)
    ) i_dispatch_queue (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_op       (in_op),
        .in_rd       (in_rd),
        .in_a        (in_a),
        .in_b        (in_b),
        .in_pc       (in_pc),
        .rob_credit  (rob_credit),
        .exec_credit (exec_credit),
        .flush       (redirect_valid),
        .in_credit   (in_credit),
        .dq_issue    (dq_issue),
        .dq_op       (dq_op),
        .dq_rd       (dq_rd),
        .dq_a        (dq_a),
        .dq_b        (dq_b),
        .dq_pc       (dq_pc)
    );

    exec_unit #(
        .EXEC_SLOTS (EXEC_SLOTS)
    ) i_exec_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .dq_issue    (dq_issue),
        .dq_op       (dq_op),
        .dq_a        (dq_a),
        .dq_b        (dq_b),
        .dq_pc       (dq_pc),
        .flush       (redirect_valid),
        .exec_credit (exec_credit),
        .cmpl_valid  (cmpl_valid),
        .cmpl_pc     (cmpl_pc),
        .cmpl_data   (cmpl_data),
        .cmpl_jpc    (cmpl_jpc)
    );

    rob #(
        .ROB_DEPTH (ROB_DEPTH)
    ) i_rob (
        .clk            (clk),
        .rst_n          (rst_n),
        .dq_issue       (dq_issue),
        .dq_rd          (dq_rd),
        .dq_pc          (dq_pc),
        .cmpl_valid     (cmpl_valid),
        .cmpl_pc        (cmpl_pc),
        .cmpl_data      (cmpl_data),
        .cmpl_jpc       (cmpl_jpc),
        .rob_credit     (rob_credit),
        .commit_valid   (commit_valid),
        .commit_pc      (commit_pc),
        .commit_rd      (commit_rd),
        .commit_data    (commit_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

//--- test/rob_core_chk.sv
`timescale 1ns/100ps

module rob_core_chk #(
    parameter int DQ_DEPTH = 4
) (
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic in_credit,
    input logic commit_valid,
    input logic redirect_valid
);

    // credits the source can hold, mirrored from the port traffic
    int src_cred;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            src_cred <= DQ_DEPTH;
        end else if (redirect_valid) begin
            src_cred <= DQ_DEPTH;
        end else begin
            src_cred <= src_cred + int'(in_credit) - int'(in_valid);
        end
    end

    quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !commit_valid && !redirect_valid)
        else $error("commit or redirect active right after reset");

    redirect_with_commit: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(redirect_valid) |-> commit_valid)
        else $error("redirect_valid rose without commit_valid");

    credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        src_cred <= DQ_DEPTH)
        else $error("in_credit pulses exceed free dispatch queue slots");

endmodule

bind rob_core_top rob_core_chk #(
    .DQ_DEPTH (DQ_DEPTH)
) i_chk (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_valid       (in_valid),
    .in_credit      (in_credit),
    .commit_valid   (commit_valid),
    .redirect_valid (redirect_valid)
);

//--- test/rob_scoreboard.sv
`timescale 1ns/100ps

module rob_scoreboard import rob_core_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  op_t             in_op,
    input  logic [rd_w-1:0] in_rd,
    input  logic [xlen-1:0] in_a,
    input  logic [xlen-1:0] in_b,
    input  logic [xlen-1:0] in_pc,
    input  logic            in_wrong,
    input  logic            commit_valid,
    input  logic [xlen-1:0] commit_pc,
    input  logic [rd_w-1:0] commit_rd,
    input  logic [xlen-1:0] commit_data,
    input  logic            redirect_valid,
    input  logic [xlen-1:0] redirect_pc,
    input  logic            end_check,
    output int              mismatch_count,
    output int              other_count,
    output int              commit_count,
    output int              pending
);

    logic [xlen-1:0] exp_pc   [$];
    logic [rd_w-1:0] exp_rd   [$];
    logic [xlen-1:0] exp_data [$];
    logic [xlen-1:0] exp_jpc  [$];

    function automatic logic [xlen-1:0] model_data(input op_t op, input logic [xlen-1:0] a,
                                                   input logic [xlen-1:0] b,
                                                   input logic [xlen-1:0] pc);
        logic [63:0] prod;
        prod = {32'd0, a} * {32'd0, b};
        if (op == op_add) return a + b;
        if (op == op_sub) return a - b;
        if (op == op_xor) return a ^ b;
        if (op == op_mul) return prod[31:0];
        if (op == op_jal) return pc + 32'd4;
        return 32'd0;
    endfunction

    // branch and jump targets
    function automatic logic [xlen-1:0] model_jpc(input op_t op, input logic [xlen-1:0] a,
                                                  input logic [xlen-1:0] b,
                                                  input logic [xlen-1:0] pc);
        if (op == op_jal) return pc + a;
        if (op == op_beq && a == b) return pc + b;
        return pc + 32'd4;
    endfunction

    task automatic report_mismatch(input string name, input logic [xlen-1:0] got,
                                   input logic [xlen-1:0] exp);
        $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        mismatch_count++;
    endtask

    initial begin
        mismatch_count = 0;
        other_count    = 0;
        commit_count   = 0;
    end

    assign pending = exp_pc.size();

    always @(posedge clk) begin
        logic [xlen-1:0] pc;
        logic [xlen-1:0] jpc;
        logic            redirect_exp;
        if (rst_n) begin
            if (commit_valid) begin
                if (exp_pc.size() == 0) begin
                    $display("Error at %0t: commit of pc %h with nothing pending",
                             $time, commit_pc);
                    other_count++;
                end else begin
                    pc  = exp_pc.pop_front();
                    jpc = exp_jpc.pop_front();
                    commit_count++;
                    if (commit_pc !== pc) report_mismatch("commit_pc", commit_pc, pc);
                    if (commit_rd !== exp_rd[0]) begin
                        report_mismatch("commit_rd", xlen'(commit_rd), xlen'(exp_rd[0]));
                    end
                    if (commit_data !== exp_data[0]) begin
                        report_mismatch("commit_data", commit_data, exp_data[0]);
                    end
                    void'(exp_rd.pop_front());
                    void'(exp_data.pop_front());
                    redirect_exp = (jpc != pc + 32'd4);
                    if (redirect_valid !== redirect_exp) begin
                        report_mismatch("redirect_valid", xlen'(redirect_valid),
                                        xlen'(redirect_exp));
                    end else if (redirect_exp && redirect_pc !== jpc) begin
                        report_mismatch("redirect_pc", redirect_pc, jpc);
                    end
                end
            end else if (redirect_valid) begin
                $display("Error at %0t: redirect raised without a commit", $time);
                other_count++;
            end
            // wrong-path sends are never expected to commit
            if (in_valid && !in_wrong) begin
                exp_pc.push_back(in_pc);
                exp_rd.push_back(in_rd);
                exp_data.push_back(model_data(in_op, in_a, in_b, in_pc));
                exp_jpc.push_back(model_jpc(in_op, in_a, in_b, in_pc));
            end
            if (end_check && exp_pc.size() != 0) begin
                $display("Error at %0t: commits stopped with %0d instructions pending",
                         $time, exp_pc.size());
                other_count++;
            end
        end
    end

endmodule

//--- test/tb_rob_core.sv
`timescale 1ns/100ps

module tb_rob_core import rob_core_pkg::*; ();

    localparam int max_lines = 64;

    logic            clk;
    logic            rst_n;
    logic            in_valid;
    op_t             in_op;
    logic [rd_w-1:0] in_rd;
    logic [xlen-1:0] in_a;
    logic [xlen-1:0] in_b;
    logic [xlen-1:0] in_pc;
    logic            in_wrong;
    logic            in_credit;
    logic            commit_valid;
    logic [xlen-1:0] commit_pc;
    logic [rd_w-1:0] commit_rd;
    logic [xlen-1:0] commit_data;
    logic            redirect_valid;
    logic [xlen-1:0] redirect_pc;
    logic            end_check;
    logic            lines_loaded;

    int mismatch_count;
    int other_count;
    int commit_count;
    int pending;
    int n_lines;

    // six words per line: op rd a b pc wrong_path
    logic [31:0] tdata [6*max_lines];
    logic [31:0] lfsr;

    rob_core_top i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .in_op          (in_op),
        .in_rd          (in_rd),
        .in_a           (in_a),
        .in_b           (in_b),
        .in_pc          (in_pc),
        .in_credit      (in_credit),
        .commit_valid   (commit_valid),
        .commit_pc      (commit_pc),
        .commit_rd      (commit_rd),
        .commit_data    (commit_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    rob_scoreboard i_sb (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .in_op          (in_op),
        .in_rd          (in_rd),
        .in_a           (in_a),
        .in_b           (in_b),
        .in_pc          (in_pc),
        .in_wrong       (in_wrong),
        .commit_valid   (commit_valid),
        .commit_pc      (commit_pc),
        .commit_rd      (commit_rd),
        .commit_data    (commit_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .end_check      (end_check),
        .mismatch_count (mismatch_count),
        .other_count    (other_count),
        .commit_count   (commit_count),
        .pending        (pending)
    );

    // galois lfsr, one step per bit
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic is_wrong(input int idx);
        return tdata[6*idx+5][0];
    endfunction

    task automatic draw_gap(output int gap);
        logic [1:0] bits;
        for (int i = 0; i < 2; i++) begin
            bits[i] = lfsr[0];
            lfsr    = lfsr_step(lfsr);
        end
        gap = int'(bits);
    endtask

    task automatic drive_line(input int idx);
        in_valid = 1'b1;
        in_op    = op_t'(tdata[6*idx][2:0]);
        in_rd    = tdata[6*idx+1][rd_w-1:0];
        in_a     = tdata[6*idx+2];
        in_b     = tdata[6*idx+3];
        in_pc    = tdata[6*idx+4];
        in_wrong = is_wrong(idx);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        wait (lines_loaded);
        repeat (20 * n_lines + 200) @(posedge clk);
        $display("Timeout: the run did not finish in time, %0d instructions pending", pending);
        $display("Verification failed");
        $finish;
    end

    initial begin
        int credits;
        int idx;
        int gap;
        logic wp_pending;
        lines_loaded = 1'b0;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_op        = op_add;
        in_rd        = '0;
        in_a         = '0;
        in_b         = '0;
        in_pc        = '0;
        in_wrong     = 1'b0;
        end_check    = 1'b0;
        lfsr         = 32'had91;
        // unread words keep the inverted address
        for (int i = 0; i < 6 * max_lines; i++) begin
            tdata[i] = ~32'(i);
        end
        $readmemh("test/rob_testdata.txt", tdata);
        n_lines = 0;
        while (n_lines < max_lines && tdata[6*n_lines] != ~32'(6 * n_lines)) begin
            n_lines++;
        end
        lines_loaded = 1'b1;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        credits    = i_dut.DQ_DEPTH;
        idx        = 0;
        gap        = 0;
        wp_pending = 1'b0;
        while (idx < n_lines) begin
            @(negedge clk);
            in_valid = 1'b0;
            if (redirect_valid) begin
                // queue is flushed, skip the rest of the wrong path
                credits    = i_dut.DQ_DEPTH;
                wp_pending = 1'b0;
                while (idx < n_lines && is_wrong(idx)) begin
                    idx++;
                end
            end else begin
                credits += int'(in_credit);
                if (gap > 0) begin
                    gap--;
                end else if (credits > 0 && !(wp_pending && !is_wrong(idx))) begin
                    drive_line(idx);
                    credits--;
                    if (is_wrong(idx)) wp_pending = 1'b1;
                    idx++;
                    draw_gap(gap);
                end
            end
        end
        @(negedge clk);
        in_valid = 1'b0;

        for (int i = 0; i < 200 && pending != 0; i++) begin
            @(negedge clk);
        end
        end_check = 1'b1;
        @(negedge clk);
        end_check = 1'b0;
        @(negedge clk);

        $display("Done: %0d commits checked, %0d mismatches, %0d other errors",
                 commit_count, mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- rob_core.f
rtl/rob_core_pkg.sv
rtl/dispatch_queue.sv
rtl/exec_unit.sv
rtl/rob.sv
rtl/rob_core_top.sv
test/rob_core_chk.sv
test/rob_scoreboard.sv
test/tb_rob_core.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rob_core \
    -f rob_core.f \
    -o sim_rob_core

./obj_dir/sim_rob_core > sim.log 2>&1
cat sim.log

if grep -q "Verification failed" sim.log; then
    exit 1
fi
exit 0

//--- test/rob_testdata.txt
// columns: op rd a b pc wrong_path (hex)
// op 0 add 1 sub 2 xor 3 mul 4 jal 5 beq
3 01 00000007 00000006 00000000 0
0 02 00000003 00000004 00000004 0
0 03 00000010 00000020 00000008 0
1 04 00000005 00000009 0000000c 0
2 05 0000ff00 00f0f0f0 00000010 0
5 00 00000001 00000002 00000014 0
4 06 00000004 00000000 00000018 0
5 00 00000024 00000024 0000001c 0
0 07 00000001 00000001 00000020 1
3 08 00000003 00000003 00000024 1
0 09 00000005 00000005 00000028 1
3 0a 00001234 00000010 00000040 0
0 0b 00000001 00000001 00000044 0
0 0c 00000002 00000002 00000048 0
2 0d 12345678 ffffffff 0000004c 0
4 0e 00000030 00000000 00000050 0
0 0f 00000007 00000007 00000054 1
1 10 00000009 00000001 00000058 1
1 11 00000100 00000001 00000080 0
3 12 ffffffff 00000002 00000084 0
0 13 00000011 00000022 00000088 0
0 14 00000033 00000044 0000008c 0
5 00 00000003 00000004 00000090 0
0 15 00000055 00000066 00000094 0
